/* hw/fp_pkg.sv */
package fp_pkg;

  // ieee single precision fields
  typedef logic [7:0]  fp_exp_t;
  typedef logic [22:0] fp_man_t;

  typedef struct packed {
    logic    sign;
    fp_exp_t expo;  // biased exponent
    fp_man_t mant;  // fraction, hidden bit not stored
  } fp_word_t;

  // a < b on raw bit patterns
  // nan and denormals fall out of the field compare as is
  function automatic logic fp_less(fp_word_t a, fp_word_t b);
    logic exp_lt;
    logic exp_eq;
    logic man_lt;
    logic mag_lt;
    exp_lt = a.expo < b.expo;
    exp_eq = a.expo == b.expo;
    man_lt = a.mant < b.mant;
    mag_lt = exp_lt | (exp_eq & man_lt);  // |a| < |b|, tie is not less
    case ({a.sign, b.sign})
      2'b10:   fp_less = 1'b1;     // neg vs pos
      2'b01:   fp_less = 1'b0;     // pos vs neg
      2'b00:   fp_less = mag_lt;
      default: fp_less = ~mag_lt;  // both neg, reversed; equal counts as less
    endcase
  endfunction

endpackage

/* hw/setup_axil_regs.sv */
`timescale 1ns/1ps
`include "setup_macros.svh"

module setup_axil_regs
  import setup_pkg::*;
(
  input  logic                     hb_clk,
  input  logic                     reset,
  input  logic [`SETUP_ADDR_W-1:0] s_awaddr,
  input  logic                     s_awvalid,
  output logic                     s_awready,
  input  logic [31:0]              s_wdata,
  input  logic [3:0]               s_wstrb,
  input  logic                     s_wvalid,
  output logic                     s_wready,
  output logic [1:0]               s_bresp,
  output logic                     s_bvalid,
  input  logic                     s_bready,
  input  logic [`SETUP_ADDR_W-1:0] s_araddr,
  input  logic                     s_arvalid,
  output logic                     s_arready,
  output logic [31:0]              s_rdata,
  output logic [1:0]               s_rresp,
  output logic                     s_rvalid,
  input  logic                     s_rready,
  cmd_if.regs                      cmd,
  res_if.status                    res
);
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [31:0]              vtx_q [9];  // v0x .. v2z
  cmd_word_u                cmd_q;
  logic [`SETUP_ADDR_W-1:0] aw_off, ar_off;
  logic [4:0]               w_slot, r_slot;  // {hit, index}
  logic                     aw_go, ar_go;
  logic                     w_is_cmd, w_ro, w_err;
  logic [31:0]              rd_word;
  logic                     rd_hit;

  // vertex word index for an offset
  function automatic logic [4:0] vtx_slot(logic [`SETUP_ADDR_W-1:0] addr);
    case (addr)
      `SETUP_V0X: vtx_slot = {1'b1, 4'd0};
      `SETUP_V0Y: vtx_slot = {1'b1, 4'd1};
      `SETUP_V0Z: vtx_slot = {1'b1, 4'd2};
      `SETUP_V1X: vtx_slot = {1'b1, 4'd3};
      `SETUP_V1Y: vtx_slot = {1'b1, 4'd4};
      `SETUP_V1Z: vtx_slot = {1'b1, 4'd5};
      `SETUP_V2X: vtx_slot = {1'b1, 4'd6};
      `SETUP_V2Y: vtx_slot = {1'b1, 4'd7};
      `SETUP_V2Z: vtx_slot = {1'b1, 4'd8};
      default:    vtx_slot = 5'd0;
    endcase
  endfunction

  // byte lane merge
  function automatic logic [31:0] merge_strb(logic [31:0] old, logic [31:0] data,
                                             logic [3:0] strb);
    merge_strb = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merge_strb[b*8 +: 8] = data[b*8 +: 8];
    end
  endfunction

  assign aw_off   = {s_awaddr[`SETUP_ADDR_W-1:2], 2'b00};  // word aligned
  assign ar_off   = {s_araddr[`SETUP_ADDR_W-1:2], 2'b00};
  assign aw_go    = s_awvalid & s_wvalid & ~s_awready & ~s_bvalid;
  assign ar_go    = s_arvalid & ~s_arready & ~s_rvalid;
  assign w_slot   = vtx_slot(aw_off);
  assign w_is_cmd = aw_off == `SETUP_CMD;
  assign w_ro     = aw_off inside {`SETUP_STATUS, `SETUP_ORDER, `SETUP_MIN, `SETUP_MAX};
  assign w_err    = (~w_slot[4] & ~w_is_cmd & ~w_ro) | (w_is_cmd & cmd.busy);

  always_ff @(posedge hb_clk) begin
    if (reset) begin
      s_awready     <= 1'b0;
      s_wready      <= 1'b0;
      s_bvalid      <= 1'b0;
      s_arready     <= 1'b0;
      s_rvalid      <= 1'b0;
      cmd.cmd_valid <= 1'b0;
    end else begin
      s_awready     <= aw_go;  // aw and w taken together
      s_wready      <= aw_go;
      cmd.cmd_valid <= aw_go & w_is_cmd & ~cmd.busy;
      if (s_awready) s_bvalid <= 1'b1;  // response the cycle after accept
      else if (s_bready) s_bvalid <= 1'b0;
      s_arready <= ar_go;
      if (s_arready) s_rvalid <= 1'b1;
      else if (s_rready) s_rvalid <= 1'b0;
    end
  end

  // write data and responses
  always_ff @(posedge hb_clk) begin
    if (aw_go) begin
      s_bresp <= w_err ? RESP_SLVERR : RESP_OKAY;
      if (w_slot[4]) vtx_q[w_slot[3:0]] <= merge_strb(vtx_q[w_slot[3:0]], s_wdata, s_wstrb);
      if (w_is_cmd && !cmd.busy) cmd_q <= merge_strb(cmd_q, s_wdata, s_wstrb);
    end
    if (s_arready) begin  // araddr still held in handshake cycle
      s_rdata <= rd_word;
      s_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  always_comb begin
    r_slot  = vtx_slot(ar_off);
    rd_hit  = 1'b1;
    rd_word = '0;  // unmapped reads return zero
    if (r_slot[4]) begin
      rd_word = vtx_q[r_slot[3:0]];
    end else begin
      case (ar_off)
        `SETUP_CMD:    rd_word = cmd_q;
        `SETUP_STATUS: rd_word = {29'd0, res.err, res.done, res.busy};
        `SETUP_ORDER:  rd_word = {26'd0, res.rd_order};
        `SETUP_MIN:    rd_word = res.rd_min;
        `SETUP_MAX:    rd_word = res.rd_max;
        default:       rd_hit  = 1'b0;
      endcase
    end
  end

  // flat words out as [vertex][axis]
  always_comb begin
    for (int v = 0; v < 3; v++) begin
      for (int a = 0; a < 3; a++) begin
        cmd.vtx[v][a] = vtx_q[v*3 + a];
      end
    end
  end

  assign cmd.cmd_word = cmd_q;

endmodule

/* hw/setup_decode.sv */
`timescale 1ns/1ps

module setup_decode
  import setup_pkg::*, fp_pkg::*;
(
  input logic hb_clk,
  input logic reset,
  cmd_if.dec  cmd,
  key_if.src  key,
  res_if.dec  res
);
  cmd_word_u cw;
  logic      is_draw, is_clear, axis_ok;
  fp_word_t  sel [3];  // sort key per vertex

  assign cw       = cmd.cmd_word;
  assign is_draw  = cw.draw.op == OP_DRAW;
  assign is_clear = cw.clear.op == OP_CLEAR;
  assign axis_ok  = cw.draw.sort_axis != AXIS_BAD;

  assign res.cmd_start = cmd.cmd_valid;  // result starts busy here
  assign cmd.busy      = res.busy;

  // axis mux, axis 3 never gets past the error check
  always_comb begin
    for (int v = 0; v < 3; v++) begin
      case (cw.draw.sort_axis)
        AXIS_X:  sel[v] = cmd.vtx[v][0];
        AXIS_Y:  sel[v] = cmd.vtx[v][1];
        default: sel[v] = cmd.vtx[v][2];
      endcase
    end
  end

  always_ff @(posedge hb_clk) begin
    if (reset) begin
      key.key_valid <= 1'b0;
      res.clr_valid <= 1'b0;
      res.err_valid <= 1'b0;
    end else begin
      key.key_valid <= cmd.cmd_valid & is_draw & axis_ok;
      res.clr_valid <= cmd.cmd_valid & is_clear;
      res.err_valid <= cmd.cmd_valid & ~(is_clear | (is_draw & axis_ok));  // bad op or axis
    end
  end

  always_ff @(posedge hb_clk) begin
    if (cmd.cmd_valid) begin
      key.key0     <= sel[0];
      key.key1     <= sel[1];
      key.key2     <= sel[2];
      res.clr_mask <= cw.clear.clear_mask;
    end
  end

endmodule

/* hw/setup_execute.sv */
`timescale 1ns/1ps

module setup_execute
  import fp_pkg::*, setup_pkg::*;
(
  input logic hb_clk,
  input logic reset,
  key_if.exe  key,
  res_if.exe  res
);
  fp_word_t   k_s1 [3];  // keys carried through stage 1
  logic       v_s1;
  logic       b10, b20, b21;  // bji: vertex j ahead of vertex i, j > i
  logic [1:0] rank0, rank1, rank2;
  order_t     order_n;

  always_ff @(posedge hb_clk) begin
    if (reset) begin
      v_s1          <= 1'b0;
      res.res_valid <= 1'b0;
    end else begin
      v_s1          <= key.key_valid;
      res.res_valid <= v_s1;
    end
  end

  // stage 1, pairwise compares
  // identical words are a tie and keep index order
  always_ff @(posedge hb_clk) begin
    if (key.key_valid) begin
      k_s1[0] <= key.key0;
      k_s1[1] <= key.key1;
      k_s1[2] <= key.key2;
      b10     <= fp_less(key.key1, key.key0) & (key.key1 != key.key0);
      b20     <= fp_less(key.key2, key.key0) & (key.key2 != key.key0);
      b21     <= fp_less(key.key2, key.key1) & (key.key2 != key.key1);
    end
  end

  // rank = count of vertices placed ahead
  assign rank0 = {1'b0, b10} + {1'b0, b20};
  assign rank1 = {1'b0, ~b10} + {1'b0, b21};
  assign rank2 = {1'b0, ~b20} + {1'b0, ~b21};

  always_comb begin
    order_n        = '0;
    order_n[rank0] = 2'd0;  // ranks distinct, every slot written
    order_n[rank1] = 2'd1;
    order_n[rank2] = 2'd2;
  end

  // stage 2, order and extremes
  always_ff @(posedge hb_clk) begin
    if (v_s1) begin
      res.order   <= order_n;
      res.min_key <= k_s1[order_n[0]];
      res.max_key <= k_s1[order_n[2]];
    end
  end

endmodule

/* hw/setup_if.sv */
`timescale 1ns/1ps

// register block to command decode
interface cmd_if import setup_pkg::*, fp_pkg::*; ();
  logic                cmd_valid;  // one cycle per accepted cmd write
  cmd_word_u           cmd_word;
  fp_word_t [2:0][2:0] vtx;        // [vertex][axis]
  logic                busy;       // lock for new cmd writes

  modport regs (output cmd_valid, cmd_word, vtx, input busy);
  modport dec  (input cmd_valid, cmd_word, vtx, output busy);
endinterface

// decode to execute, one key per vertex
interface key_if import fp_pkg::*; ();
  logic     key_valid;
  fp_word_t key0;
  fp_word_t key1;
  fp_word_t key2;

  modport src (output key_valid, key0, key1, key2);
  modport exe (input key_valid, key0, key1, key2);
endinterface

// execute and decode into result, status back to regs
interface res_if import setup_pkg::*, fp_pkg::*; ();
  logic     res_valid;
  order_t   order;
  fp_word_t min_key;
  fp_word_t max_key;
  logic     cmd_start;  // cmd_valid seen by decode
  logic     clr_valid;
  logic [2:0] clr_mask;
  logic     err_valid;
  logic     busy;
  logic     done;
  logic     err;
  order_t   rd_order;   // readback copies
  fp_word_t rd_min;
  fp_word_t rd_max;

  modport exe (output res_valid, order, min_key, max_key);
  modport dec (output cmd_start, clr_valid, clr_mask, err_valid, input busy);
  modport res (input res_valid, order, min_key, max_key, cmd_start, clr_valid,
               clr_mask, err_valid, output busy, done, err, rd_order, rd_min, rd_max);
  modport status (input busy, done, err, rd_order, rd_min, rd_max);
endinterface

/* hw/setup_pkg.sv */
`include "setup_macros.svh"

package setup_pkg;

  // cmd[31:30]; 00 and 11 are rejected
  typedef enum logic [1:0] {
    OP_NONE  = 2'b00,
    OP_DRAW  = `SETUP_OP_DRAW,
    OP_CLEAR = `SETUP_OP_CLEAR,
    OP_RSVD  = 2'b11
  } opcode_e;

  typedef enum logic [1:0] {
    AXIS_X   = 2'd0,
    AXIS_Y   = 2'd1,
    AXIS_Z   = 2'd2,
    AXIS_BAD = 2'd3   // flagged as error by decode
  } axis_e;

  typedef struct packed {
    opcode_e     op;
    logic [27:0] rsvd;
    axis_e       sort_axis;
  } draw_cmd_t;

  // mask bit 0 order, bit 1 min, bit 2 max
  typedef struct packed {
    opcode_e     op;
    logic [26:0] rsvd;
    logic [2:0]  clear_mask;
  } clear_cmd_t;

  // same word, view picked by op
  typedef union packed {
    draw_cmd_t  draw;
    clear_cmd_t clear;
  } cmd_word_u;

  typedef logic [2:0][1:0] order_t;  // [slot] = vertex index, slot 0 smallest

endpackage

/* hw/setup_result.sv */
`timescale 1ns/1ps

module setup_result (
  input logic hb_clk,
  input logic reset,
  res_if.res  res
);
  logic busy_q;

  // busy from the cmd_valid cycle itself
  assign res.busy = busy_q | res.cmd_start;

  always_ff @(posedge hb_clk) begin
    if (reset) begin
      busy_q       <= 1'b0;
      res.done     <= 1'b0;
      res.err      <= 1'b0;
      res.rd_order <= '0;
      res.rd_min   <= '0;
      res.rd_max   <= '0;
    end else begin
      if (res.cmd_start) begin
        busy_q   <= 1'b1;
        res.done <= 1'b0;  // new cmd drops old status
        res.err  <= 1'b0;
      end
      if (res.res_valid) begin  // draw finished
        busy_q       <= 1'b0;
        res.done     <= 1'b1;
        res.rd_order <= res.order;
        res.rd_min   <= res.min_key;
        res.rd_max   <= res.max_key;
      end
      if (res.clr_valid) begin
        busy_q   <= 1'b0;
        res.done <= 1'b1;
        if (res.clr_mask[0]) res.rd_order <= '0;
        if (res.clr_mask[1]) res.rd_min   <= '0;
        if (res.clr_mask[2]) res.rd_max   <= '0;
      end
      if (res.err_valid) begin  // results untouched
        busy_q  <= 1'b0;
        res.err <= 1'b1;
      end
    end
  end

endmodule

/* hw/setup_top.sv */
`timescale 1ns/1ps
`include "setup_macros.svh"

module setup_top (
  input  logic                     hb_clk,
  input  logic                     reset,
  input  logic [`SETUP_ADDR_W-1:0] s_awaddr,
  input  logic                     s_awvalid,
  output logic                     s_awready,
  input  logic [31:0]              s_wdata,
  input  logic [3:0]               s_wstrb,
  input  logic                     s_wvalid,
  output logic                     s_wready,
  output logic [1:0]               s_bresp,
  output logic                     s_bvalid,
  input  logic                     s_bready,
  input  logic [`SETUP_ADDR_W-1:0] s_araddr,
  input  logic                     s_arvalid,
  output logic                     s_arready,
  output logic [31:0]              s_rdata,
  output logic [1:0]               s_rresp,
  output logic                     s_rvalid,
  input  logic                     s_rready
);
  cmd_if cmd_bus ();  // regs to decode
  key_if key_bus ();  // decode to execute
  res_if res_bus ();  // into result, status back

  setup_axil_regs u_regs (
    .hb_clk    (hb_clk),    .reset     (reset),
    .s_awaddr  (s_awaddr),  .s_awvalid (s_awvalid), .s_awready (s_awready),
    .s_wdata   (s_wdata),   .s_wstrb   (s_wstrb),   .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),  .s_bresp   (s_bresp),   .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),  .s_araddr  (s_araddr),  .s_arvalid (s_arvalid),
    .s_arready (s_arready), .s_rdata   (s_rdata),   .s_rresp   (s_rresp),
    .s_rvalid  (s_rvalid),  .s_rready  (s_rready),
    .cmd       (cmd_bus),
    .res       (res_bus)
  );

  setup_decode u_decode (
    .hb_clk (hb_clk),
    .reset  (reset),
    .cmd    (cmd_bus),
    .key    (key_bus),
    .res    (res_bus)
  );

  setup_execute u_execute (
    .hb_clk (hb_clk),
    .reset  (reset),
    .key    (key_bus),
    .res    (res_bus)
  );

  setup_result u_result (
    .hb_clk (hb_clk),
    .reset  (reset),
    .res    (res_bus)
  );

endmodule

/* include/setup_macros.svh */
`ifndef SETUP_MACROS_SVH
`define SETUP_MACROS_SVH

// host bus byte address width
`define SETUP_ADDR_W 6

// vertex words, x y z per vertex
`define SETUP_V0X 6'h00
`define SETUP_V0Y 6'h04
`define SETUP_V0Z 6'h08
`define SETUP_V1X 6'h0C
`define SETUP_V1Y 6'h10
`define SETUP_V1Z 6'h14
`define SETUP_V2X 6'h18
`define SETUP_V2Y 6'h1C
`define SETUP_V2Z 6'h20

`define SETUP_CMD    6'h24  // command, write starts engine
`define SETUP_STATUS 6'h28  // {err, done, busy}
`define SETUP_ORDER  6'h2C  // vertex order, slot 0 in [1:0]
`define SETUP_MIN    6'h30
`define SETUP_MAX    6'h34

// opcode in cmd[31:30]
`define SETUP_OP_DRAW  2'b01
`define SETUP_OP_CLEAR 2'b10

`endif

/* sim.f */
+incdir+include
hw/fp_pkg.sv
hw/setup_pkg.sv
hw/setup_if.sv
hw/setup_axil_regs.sv
hw/setup_decode.sv
hw/setup_execute.sv
hw/setup_result.sv
hw/setup_top.sv
verif/setup_chk.sv
verif/setup_tb.sv

/* verif/setup_chk.sv */
`timescale 1ns/1ps
`include "setup_macros.svh"

module setup_chk (
  input logic                     hb_clk,
  input logic                     reset,
  input logic [`SETUP_ADDR_W-1:0] s_awaddr,
  input logic [31:0]              s_wdata,
  input logic [3:0]               s_wstrb,
  input logic                     s_awready,
  input logic [1:0]               s_bresp,
  input logic                     s_bvalid,
  input logic                     s_bready,
  input logic                     s_rvalid,
  input logic                     s_rready,
  input logic                     res_valid,
  input logic                     done,
  input logic [5:0]               order,
  input logic [31:0]              min_key,
  input logic [31:0]              max_key
);
  logic draw_acc;
  int   fail_cnt = 0;  // failed assertions so far

  // sign first, then exponent and mantissa as one magnitude
  function automatic logic word_lt(logic [31:0] a, logic [31:0] b);
    if (a[31] != b[31]) word_lt = a[31];
    else if (!a[31]) word_lt = a[30:0] < b[30:0];
    else word_lt = a[30:0] >= b[30:0];  // negatives reversed and a tie is less
  endfunction

  function automatic logic is_perm(logic [5:0] o);
    is_perm = o[1:0] != o[3:2] && o[1:0] != o[5:4] && o[3:2] != o[5:4]
              && o[1:0] != 2'd3 && o[3:2] != 2'd3 && o[5:4] != 2'd3;
  endfunction

  // cmd handshake cycle of a good draw with its okay response registered
  assign draw_acc = s_awready && s_awaddr == `SETUP_CMD && s_wstrb == 4'hF
                    && s_bresp == 2'b00 && s_wdata[31:30] == `SETUP_OP_DRAW
                    && s_wdata[1:0] != 2'd3;

  a_bvalid_hold: assert property (@(posedge hb_clk) disable iff (reset)
    s_bvalid && !s_bready |=> s_bvalid)
    else begin
      fail_cnt++;
      $error("bvalid dropped before bready");
    end

  a_rvalid_hold: assert property (@(posedge hb_clk) disable iff (reset)
    s_rvalid && !s_rready |=> s_rvalid)
    else begin
      fail_cnt++;
      $error("rvalid dropped before rready");
    end

  a_draw_done: assert property (@(posedge hb_clk) disable iff (reset)
    draw_acc |=> !done ##3 done)
    else begin
      fail_cnt++;
      $error("done not 4 cycles after draw accept");
    end

  a_order_perm: assert property (@(posedge hb_clk) disable iff (reset)
    res_valid |=> done && is_perm(order))
    else begin
      fail_cnt++;
      $error("order is not a permutation");
    end

  a_min_max: assert property (@(posedge hb_clk) disable iff (reset)
    res_valid |=> min_key == max_key || !word_lt(max_key, min_key))
    else begin
      fail_cnt++;
      $error("max key ranks below min key");
    end

endmodule

bind setup_top setup_chk chk0 (
  .hb_clk, .reset, .s_awaddr, .s_wdata, .s_wstrb, .s_awready, .s_bresp,
  .s_bvalid, .s_bready, .s_rvalid, .s_rready,
  .res_valid (res_bus.res_valid),
  .done      (res_bus.done),
  .order     (res_bus.rd_order),
  .min_key   (res_bus.rd_min),
  .max_key   (res_bus.rd_max)
);

/* verif/setup_tb.sv */
`timescale 1ns/1ps
`include "setup_macros.svh"

module setup_tb;
  localparam int AW    = `SETUP_ADDR_W;
  localparam int LIMIT = 50;  // cycles allowed per handshake

  logic          hb_clk;
  logic          reset;
  logic [AW-1:0] s_awaddr, s_araddr;
  logic          s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready;
  logic [31:0]   s_wdata;
  logic [3:0]    s_wstrb;
  logic          s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
  logic [1:0]    s_bresp, s_rresp;
  logic [31:0]   s_rdata;

  logic [31:0] vtx [9];  // v0x .. v2z
  logic [1:0]  resp;
  logic [31:0] rd;
  int          checks, errors, test_err;
  string       rname [3] = '{"order", "min_key", "max_key"};

  setup_top dut0 (.*);

  initial begin
    hb_clk = 1'b0;
    forever #4 hb_clk = ~hb_clk;
  end

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic note_timeout(string what);
    errors++;
    $display("%0t: %s never arrived within %0d cycles", $time, what, LIMIT);
  endtask

  task automatic report_test(string name);
    $display("%s: %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  // called on a rising edge, returns on one
  task automatic axi_write(logic [AW-1:0] addr, logic [31:0] data, int b_hold,
                           output logic [1:0] bresp_o);
    int n;
    s_awaddr  <= addr;
    s_awvalid <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= 4'hF;
    s_wvalid  <= 1'b1;
    s_bready  <= (b_hold == 0);
    n = 0;
    do begin
      @(posedge hb_clk);
      n++;
    end while (!s_awready && n < LIMIT);
    if (!s_awready) note_timeout("awready");
    else check_val("wready", s_wready, 1'b1);  // pulses with awready
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    repeat (b_hold) @(posedge hb_clk);  // bready held low meanwhile
    s_bready <= 1'b1;
    n = 0;
    do begin
      @(posedge hb_clk);
      n++;
    end while (!(s_bvalid && s_bready) && n < LIMIT);
    if (!(s_bvalid && s_bready)) note_timeout("bvalid");
    bresp_o = s_bresp;
    s_bready <= 1'b0;
  endtask

  task automatic axi_read(logic [AW-1:0] addr, int r_hold, output logic [31:0] data,
                          output logic [1:0] rresp_o);
    int n;
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    s_rready  <= (r_hold == 0);
    n = 0;
    do begin
      @(posedge hb_clk);
      n++;
    end while (!s_arready && n < LIMIT);
    if (!s_arready) note_timeout("arready");
    s_arvalid <= 1'b0;
    repeat (r_hold) @(posedge hb_clk);
    s_rready <= 1'b1;
    n = 0;
    do begin
      @(posedge hb_clk);
      n++;
    end while (!(s_rvalid && s_rready) && n < LIMIT);
    if (!(s_rvalid && s_rready)) note_timeout("rvalid");
    data    = s_rdata;
    rresp_o = s_rresp;
    s_rready <= 1'b0;
  endtask

  // poll STATUS until not busy with done or err
  task automatic wait_idle(output logic [31:0] status);
    int n;
    n = 0;
    do begin
      axi_read(`SETUP_STATUS, 0, status, resp);
      n++;
    end while ((status[0] || !(status[1] || status[2])) && n < LIMIT);
    if (status[0] || !(status[1] || status[2])) note_timeout("idle status");
  endtask

  task automatic read_results(output logic [31:0] r [3]);
    axi_read(`SETUP_ORDER, 0, r[0], resp);
    axi_read(`SETUP_MIN, 0, r[1], resp);
    axi_read(`SETUP_MAX, 0, r[2], resp);
  endtask

  // negatives compare reversed and equal negatives count as less
  function automatic bit key_lt(logic [31:0] a, logic [31:0] b);
    if (a[31] != b[31]) key_lt = a[31];
    else if (!a[31]) key_lt = a[30:0] < b[30:0];
    else key_lt = a[30:0] >= b[30:0];
  endfunction

  // identical words fall back to index order
  function automatic bit ahead(logic [31:0] kj, logic [31:0] ki, int j, int i);
    ahead = (kj == ki) ? (j < i) : key_lt(kj, ki);
  endfunction

  task automatic set_keys(int axis, logic [31:0] a, logic [31:0] b, logic [31:0] c);
    for (int i = 0; i < 9; i++) vtx[i] = $urandom;  // other axes are noise
    vtx[axis]     = a;
    vtx[3 + axis] = b;
    vtx[6 + axis] = c;
  endtask

  task automatic run_draw(int axis);
    logic [31:0] k [3];
    logic [5:0]  exp_order;
    logic [31:0] st;
    logic [31:0] cur [3];
    int          r;
    exp_order = '0;
    for (int i = 0; i < 3; i++) k[i] = vtx[i*3 + axis];
    for (int i = 0; i < 3; i++) begin
      r = 0;
      for (int j = 0; j < 3; j++) begin
        if (j != i && ahead(k[j], k[i], j, i)) r++;
      end
      exp_order[r*2 +: 2] = 2'(i);
    end
    for (int i = 0; i < 9; i++) axi_write(AW'(i * 4), vtx[i], 0, resp);
    axi_write(`SETUP_CMD, {`SETUP_OP_DRAW, 28'd0, 2'(axis)}, 0, resp);
    check_val("bresp", resp, 2'b00);
    wait_idle(st);
    check_val("status", st, 32'h2);
    read_results(cur);
    check_val("order", cur[0], {26'd0, exp_order});
    check_val("min_key", cur[1], k[exp_order[1:0]]);
    check_val("max_key", cur[2], k[exp_order[5:4]]);
  endtask

  initial begin
    logic [31:0] st;
    logic [31:0] keep [3];
    logic [31:0] cur [3];
    logic [31:0] bad [3];
    void'($urandom(45));
    reset     <= 1'b1;
    s_awaddr  <= '0;
    s_awvalid <= 1'b0;
    s_wdata   <= '0;
    s_wstrb   <= '0;
    s_wvalid  <= 1'b0;
    s_bready  <= 1'b0;
    s_araddr  <= '0;
    s_arvalid <= 1'b0;
    s_rready  <= 1'b0;
    checks   = 0;
    errors   = 0;
    test_err = 0;
    repeat (4) @(posedge hb_clk);
    reset <= 1'b0;
    @(posedge hb_clk);

    set_keys(1, 32'h4040_0000, 32'h3FC0_0000, 32'h4020_0000);  // 3.0 1.5 2.5
    run_draw(1);
    set_keys(1, 32'h3F80_0000, 32'hC000_0000, 32'h3F00_0000);  // 1.0 -2.0 0.5
    run_draw(1);
    set_keys(1, 32'hBF80_0000, 32'hC040_0000, 32'hBE80_0000);  // -1.0 -3.0 -0.25
    run_draw(1);
    report_test("draw on y");

    set_keys(0, 32'h4100_0000, 32'hBF00_0000, 32'h3E00_0000);
    run_draw(0);
    set_keys(2, 32'hC1A0_0000, 32'h4120_0000, 32'hC080_0000);
    run_draw(2);
    for (int t = 0; t < 200; t++) begin
      for (int i = 0; i < 9; i++) vtx[i] = $urandom;
      run_draw($urandom_range(2, 0));
    end
    report_test("draw on x, z and random");

    set_keys(1, 32'h4000_0000, 32'h4000_0000, 32'h4000_0000);
    run_draw(1);
    set_keys(0, 32'hBF80_0000, 32'hBF80_0000, 32'hBF80_0000);  // equal negatives
    run_draw(0);
    set_keys(2, 32'hC0A0_0000, 32'hBF80_0000, 32'hC0A0_0000);
    run_draw(2);
    set_keys(2, 32'h0000_0000, 32'h8000_0000, 32'h0000_0000);  // +0 -0 +0
    run_draw(2);
    report_test("equal keys");

    set_keys(1, 32'h4040_0000, 32'h3F80_0000, 32'h4000_0000);
    for (int m = 1; m < 8; m++) begin
      run_draw(1);
      read_results(keep);
      axi_write(`SETUP_CMD, {`SETUP_OP_CLEAR, 27'd0, 3'(m)}, 0, resp);
      wait_idle(st);
      check_val("status", st, 32'h2);
      read_results(cur);
      for (int i = 0; i < 3; i++) check_val(rname[i], cur[i], m[i] ? 32'd0 : keep[i]);
    end
    bad[0] = 32'h0000_0001;  // opcode 00
    bad[1] = {2'b11, 30'd0};
    bad[2] = {`SETUP_OP_DRAW, 28'd0, 2'd3};  // axis 3
    run_draw(0);
    read_results(keep);
    for (int b = 0; b < 3; b++) begin
      axi_write(`SETUP_CMD, bad[b], 0, resp);
      wait_idle(st);
      check_val("status", st, 32'h4);
      read_results(cur);
      for (int i = 0; i < 3; i++) check_val(rname[i], cur[i], keep[i]);
    end
    report_test("clear and error");

    set_keys(2, 32'h4100_0000, 32'hC100_0000, 32'h3F00_0000);
    run_draw(2);
    read_results(keep);
    axi_write(`SETUP_CMD, {`SETUP_OP_DRAW, 28'd0, 2'd2}, 0, resp);
    check_val("bresp", resp, 2'b00);
    axi_write(`SETUP_CMD, {`SETUP_OP_CLEAR, 27'd0, 3'b111}, 0, resp);  // lands while busy
    check_val("bresp", resp, 2'b10);
    wait_idle(st);
    read_results(cur);
    for (int i = 0; i < 3; i++) check_val(rname[i], cur[i], keep[i]);
    axi_read(AW'(6'h38), 0, rd, resp);
    check_val("rdata", rd, 32'd0);
    check_val("rresp", resp, 2'b10);
    axi_write(`SETUP_V1Y, 32'h1234_5678, 6, resp);  // slow bready
    check_val("bresp", resp, 2'b00);
    axi_read(`SETUP_V1Y, 6, rd, resp);  // slow rready
    check_val("rdata", rd, 32'h1234_5678);
    check_val("rresp", resp, 2'b00);
    report_test("responses");

    errors += dut0.chk0.fail_cnt;  // bound protocol and result assertions
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
